// File: Makefile
# Verilator simulation of the DDR PHY testbench

VERILATOR ?= verilator
TOP       ?= tb_phy
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Finished with errors
VFLAGS    ?= --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: phy_addr_cmd.sv
/*
 * Address and command path
 * Registers AFI commands onto the memory pins and the clock enable,
 * with the idle command held while in reset
 */
`timescale 1ns/1ps

module phy_addr_cmd
	import phy_pkg::*;
(
	input  logic     pll_afi_clk,
	input  logic     rst_n,
	input  mem_cmd_t afi_cmd,
	input  logic     afi_mem_clk_disable,
	output mem_cmd_t mem_cmd,
	output logic     mem_ck_en
);

	always_ff @(posedge pll_afi_clk or negedge rst_n) begin
		if (!rst_n) begin
			// Deselected, CKE low, memory held in reset
			mem_cmd       <= '0;
			mem_cmd.cs_n  <= 1'b1;
			mem_cmd.ras_n <= 1'b1;
			mem_cmd.cas_n <= 1'b1;
			mem_cmd.we_n  <= 1'b1;
			mem_ck_en     <= 1'b0;
		end else begin
			mem_cmd   <= afi_cmd;
			mem_ck_en <= ~afi_mem_clk_disable;
		end
	end

endmodule

// File: phy_pkg.sv
/*
 * Shared definitions for the full-rate DDR PHY
 * Interface widths, latency defaults, the sequencer register map,
 * the command and write beat structs and the Avalon FSM states
 */
package phy_pkg;

	// Memory interface widths
	localparam int MEM_ADDR_W = 15;
	localparam int MEM_BANK_W = 3;
	localparam int MEM_DQ_W   = 16;
	localparam int MEM_DM_W   = MEM_DQ_W / 8;

	// Latency fields and the delay lines they index
	localparam int WLAT_W   = 4;
	localparam int RLAT_W   = 5;
	localparam int WR_DEPTH = 2 ** WLAT_W;
	localparam int RD_DEPTH = 2 ** RLAT_W;

	localparam int RESET_SYNC_STAGES = 3;
	localparam int CALIB_REG_W       = 8;

	// Sequencer port
	localparam int AVL_ADDR_W = 4;
	localparam int AVL_DATA_W = 32;

	typedef logic [MEM_ADDR_W-1:0]  mem_addr_t;
	typedef logic [MEM_BANK_W-1:0]  mem_bank_t;
	typedef logic [MEM_DQ_W-1:0]    dq_t;
	typedef logic [MEM_DM_W-1:0]    dm_t;
	typedef logic [WLAT_W-1:0]      wlat_t;
	typedef logic [RLAT_W-1:0]      rlat_t;
	typedef logic [CALIB_REG_W-1:0] calib_t;
	typedef logic [AVL_ADDR_W-1:0]  avl_addr_t;
	typedef logic [AVL_DATA_W-1:0]  avl_data_t;

	localparam wlat_t WLAT_DEFAULT = wlat_t'(2);
	localparam rlat_t RLAT_DEFAULT = rlat_t'(4);

	// Seven skip-step bits above the skip-memory-init bit, all set
	localparam calib_t CALIB_INIT = '1;

	// Register map
	localparam avl_addr_t REG_STATUS = avl_addr_t'(0);
	localparam avl_addr_t REG_WLAT   = avl_addr_t'(1);
	localparam avl_addr_t REG_RLAT   = avl_addr_t'(2);
	localparam avl_addr_t REG_CALIB  = avl_addr_t'(3);

	// One command word, AFI side and pin side alike
	typedef struct packed {
		mem_addr_t addr;
		mem_bank_t ba;
		logic      cs_n;
		logic      ras_n;
		logic      cas_n;
		logic      we_n;
		logic      cke;
		logic      odt;
		logic      rst_n;
	} mem_cmd_t;

	typedef struct packed {
		logic valid;
		dq_t  data;
		dm_t  dm;
	} wr_beat_t;

	typedef enum logic {
		AVL_IDLE,
		AVL_READ_WAIT
	} avl_state_t;

endpackage

// File: phy_read_path.sv
/*
 * Read data path
 * Tracks each read enable through the read latency and returns
 * the captured DQ word with afi_rdata_valid
 */
`timescale 1ns/1ps

module phy_read_path
	import phy_pkg::*;
(
	input  logic  pll_afi_clk,
	input  logic  rst_n,
	input  logic  afi_rdata_en,
	input  rlat_t afi_rlat,
	input  dq_t   mem_dq_in,
	output dq_t   afi_rdata,
	output logic  afi_rdata_valid
);

	logic [RD_DEPTH-1:0] en_sr;
	logic [RD_DEPTH-1:0] en_nxt;
	rlat_t               rd_slot;
	dq_t                 dq_q;

	// Enable enters one slot short as the capture stage adds the last cycle
	assign rd_slot = afi_rlat - 1'b1;

	always_comb begin
		en_nxt = en_sr >> 1;
		if (afi_rdata_en) begin
			en_nxt[rd_slot] = 1'b1;
		end
	end

	always_ff @(posedge pll_afi_clk or negedge rst_n) begin
		if (!rst_n) begin
			en_sr           <= '0;
			afi_rdata_valid <= 1'b0;
		end else begin
			en_sr           <= en_nxt;
			afi_rdata_valid <= en_sr[0];
		end
	end

	// Input capture of the pins every cycle
	always_ff @(posedge pll_afi_clk) begin
		dq_q <= mem_dq_in;
		if (en_sr[0]) begin
			afi_rdata <= dq_q;
		end
	end

	a_rlat_nonzero: assert property (@(posedge pll_afi_clk) disable iff (!rst_n)
		afi_rdata_en |-> afi_rlat != '0);

endmodule

// File: phy_reset_sync.sv
/*
 * PHY reset synchronizer
 * Global reset, soft reset and PLL lock clear the chain at once;
 * release reaches afi_reset_n after RESET_SYNC_STAGES clock edges
 */
`timescale 1ns/1ps

module phy_reset_sync
	import phy_pkg::*;
(
	input  logic pll_afi_clk,
	input  logic rst_n,
	input  logic soft_reset_n,
	input  logic pll_locked,
	output logic afi_reset_n
);

	logic                         arst_n;
	logic [RESET_SYNC_STAGES-1:0] sync_q;

	// Any source low holds the whole chain in reset
	assign arst_n = rst_n & soft_reset_n & pll_locked;

	always_ff @(posedge pll_afi_clk or negedge arst_n) begin
		if (!arst_n) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[RESET_SYNC_STAGES-2:0], 1'b1};
		end
	end

	assign afi_reset_n = sync_q[RESET_SYNC_STAGES-1];

	// Loss of lock must never let the PHY out of reset
	a_no_release_unlocked: assert property (@(posedge pll_afi_clk) disable iff (!rst_n)
		!$past(pll_locked) |-> !afi_reset_n);

endmodule

// File: phy_seq_csr.sv
/*
 * Sequencer register file on the Avalon port
 * Holds calibration status, write and read latency and the skip mask;
 * reads take one wait state, writes complete at once
 */
`timescale 1ns/1ps

module phy_seq_csr
	import phy_pkg::*;
(
	input  logic       pll_afi_clk,
	input  logic       rst_n,
	input  logic       avl_read,
	input  logic       avl_write,
	input  avl_addr_t  avl_address,
	input  avl_data_t  avl_writedata,
	output avl_data_t  avl_readdata,
	output logic       avl_waitrequest,
	output logic       afi_cal_success,
	output logic       afi_cal_fail,
	output wlat_t      afi_wlat,
	output rlat_t      afi_rlat
);

	avl_state_t state, state_nxt;
	avl_data_t  rd_mux;
	avl_data_t  readdata_q;
	calib_t     calib_q;

	// Register writes
	always_ff @(posedge pll_afi_clk or negedge rst_n) begin
		if (!rst_n) begin
			afi_cal_success <= 1'b0;
			afi_cal_fail    <= 1'b0;
			afi_wlat        <= WLAT_DEFAULT;
			afi_rlat        <= RLAT_DEFAULT;
			calib_q         <= CALIB_INIT;
		end else if (avl_write) begin
			case (avl_address)
				REG_STATUS: begin
					// Fail takes priority over success
					afi_cal_fail    <= avl_writedata[1];
					afi_cal_success <= avl_writedata[0] & ~avl_writedata[1];
				end
				REG_WLAT:  afi_wlat <= avl_writedata[WLAT_W-1:0];
				REG_RLAT:  afi_rlat <= avl_writedata[RLAT_W-1:0];
				REG_CALIB: calib_q  <= avl_writedata[CALIB_REG_W-1:0];
				default: ;
			endcase
		end
	end

	// Read mux with zero for unused addresses
	always_comb begin
		rd_mux = '0;
		case (avl_address)
			REG_STATUS: begin
				rd_mux[0] = afi_cal_success;
				rd_mux[1] = afi_cal_fail;
			end
			REG_WLAT:  rd_mux[WLAT_W-1:0] = afi_wlat;
			REG_RLAT:  rd_mux[RLAT_W-1:0] = afi_rlat;
			REG_CALIB: rd_mux[CALIB_REG_W-1:0] = calib_q;
			default:   rd_mux = '0;
		endcase
	end

	// One wait state per read
	always_comb begin
		state_nxt = state;
		case (state)
			AVL_IDLE:      if (avl_read) state_nxt = AVL_READ_WAIT;
			AVL_READ_WAIT: state_nxt = AVL_IDLE;
			default:       state_nxt = AVL_IDLE;
		endcase
	end

	always_ff @(posedge pll_afi_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= AVL_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_ff @(posedge pll_afi_clk) begin
		if (state == AVL_IDLE && avl_read) begin
			readdata_q <= rd_mux;
		end
	end

	assign avl_waitrequest = (state == AVL_IDLE) && avl_read;
	assign avl_readdata    = readdata_q;

	a_cal_exclusive: assert property (@(posedge pll_afi_clk) disable iff (!rst_n)
		!(afi_cal_success && afi_cal_fail));

endmodule

// File: phy_top.sv
/*
 * Full-rate DDR PHY top level
 * Reset synchronizer, sequencer registers and the command,
 * write and read paths, all on pll_afi_clk
 */
`timescale 1ns/1ps

module phy_top
	import phy_pkg::*;
(
	input  logic      pll_afi_clk,
	input  logic      rst_n,
	input  logic      soft_reset_n,
	input  logic      pll_locked,
	output logic      afi_reset_n,
	// Sequencer port
	input  logic      avl_read,
	input  logic      avl_write,
	input  avl_addr_t avl_address,
	input  avl_data_t avl_writedata,
	output avl_data_t avl_readdata,
	output logic      avl_waitrequest,
	output logic      afi_cal_success,
	output logic      afi_cal_fail,
	output wlat_t     afi_wlat,
	output rlat_t     afi_rlat,
	// Address and command
	input  mem_cmd_t  afi_cmd,
	input  logic      afi_mem_clk_disable,
	output mem_cmd_t  mem_cmd,
	output logic      mem_ck_en,
	// AFI write and read data
	input  logic      afi_wdata_valid,
	input  dq_t       afi_wdata,
	input  dm_t       afi_dm,
	input  logic      afi_rdata_en,
	output dq_t       afi_rdata,
	output logic      afi_rdata_valid,
	// Memory data pins
	output dq_t       mem_dq_out,
	output logic      mem_dq_oe,
	output dm_t       mem_dm,
	input  dq_t       mem_dq_in
);

	phy_reset_sync u_reset_sync (
		.pll_afi_clk  (pll_afi_clk),
		.rst_n        (rst_n),
		.soft_reset_n (soft_reset_n),
		.pll_locked   (pll_locked),
		.afi_reset_n  (afi_reset_n)
	);

	phy_seq_csr u_seq_csr (
		.pll_afi_clk     (pll_afi_clk),
		.rst_n           (afi_reset_n),
		.avl_read        (avl_read),
		.avl_write       (avl_write),
		.avl_address     (avl_address),
		.avl_writedata   (avl_writedata),
		.avl_readdata    (avl_readdata),
		.avl_waitrequest (avl_waitrequest),
		.afi_cal_success (afi_cal_success),
		.afi_cal_fail    (afi_cal_fail),
		.afi_wlat        (afi_wlat),
		.afi_rlat        (afi_rlat)
	);

	phy_addr_cmd u_addr_cmd (
		.pll_afi_clk         (pll_afi_clk),
		.rst_n               (afi_reset_n),
		.afi_cmd             (afi_cmd),
		.afi_mem_clk_disable (afi_mem_clk_disable),
		.mem_cmd             (mem_cmd),
		.mem_ck_en           (mem_ck_en)
	);

	phy_write_path u_write_path (
		.pll_afi_clk     (pll_afi_clk),
		.rst_n           (afi_reset_n),
		.afi_wdata_valid (afi_wdata_valid),
		.afi_wdata       (afi_wdata),
		.afi_dm          (afi_dm),
		.afi_wlat        (afi_wlat),
		.mem_dq_out      (mem_dq_out),
		.mem_dq_oe       (mem_dq_oe),
		.mem_dm          (mem_dm)
	);

	phy_read_path u_read_path (
		.pll_afi_clk     (pll_afi_clk),
		.rst_n           (afi_reset_n),
		.afi_rdata_en    (afi_rdata_en),
		.afi_rlat        (afi_rlat),
		.mem_dq_in       (mem_dq_in),
		.afi_rdata       (afi_rdata),
		.afi_rdata_valid (afi_rdata_valid)
	);

endmodule

// File: phy_write_path.sv
/*
 * Write data path
 * Delays each AFI write beat by the write latency, then drives DQ,
 * DQ output enable and DM for one cycle
 */
`timescale 1ns/1ps

module phy_write_path
	import phy_pkg::*;
(
	input  logic  pll_afi_clk,
	input  logic  rst_n,
	input  logic  afi_wdata_valid,
	input  dq_t   afi_wdata,
	input  dm_t   afi_dm,
	input  wlat_t afi_wlat,
	output dq_t   mem_dq_out,
	output logic  mem_dq_oe,
	output dm_t   mem_dm
);

	wr_beat_t stage     [WR_DEPTH];
	wr_beat_t stage_nxt [WR_DEPTH];
	wr_beat_t in_beat;

	assign in_beat = '{valid: afi_wdata_valid, data: afi_wdata, dm: afi_dm};

	// Slot k holds the beat that reaches the pins k edges later
	always_comb begin
		for (int i = 0; i < WR_DEPTH - 1; i++) begin
			stage_nxt[i] = stage[i + 1];
		end
		stage_nxt[WR_DEPTH-1] = '0;
		if (afi_wdata_valid) begin
			stage_nxt[afi_wlat] = in_beat;
		end
	end

	always_ff @(posedge pll_afi_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < WR_DEPTH; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage <= stage_nxt;
		end
	end

	assign mem_dq_out = stage[0].data;
	assign mem_dq_oe  = stage[0].valid;
	assign mem_dm     = stage[0].dm;

	a_wlat_nonzero: assert property (@(posedge pll_afi_clk) disable iff (!rst_n)
		afi_wdata_valid |-> afi_wlat != '0);

endmodule

// File: src.f
phy_pkg.sv
phy_reset_sync.sv
phy_seq_csr.sv
phy_addr_cmd.sv
phy_write_path.sv
phy_read_path.sv
phy_top.sv
tb_phy.sv

// File: tb_phy.sv
/*
 * Directed testbench for the full-rate DDR PHY
 * Covers reset sequencing, the sequencer registers, the command path
 * and the write and read latency lines
 */
`timescale 1ns/1ps

module tb_phy
	import phy_pkg::*;
();

	localparam int          CLK_PERIOD  = 8;
	localparam int          WAIT_LIMIT  = 50;
	localparam int          WR_TEST_LAT = 3;
	localparam int          RD_TEST_LAT = 5;
	localparam int          BEATS       = 24;
	localparam logic [31:0] LFSR_SEED   = 32'h0874_8ece;

	logic      pll_afi_clk;
	logic      rst_n;
	logic      soft_reset_n;
	logic      pll_locked;
	logic      afi_reset_n;
	logic      avl_read;
	logic      avl_write;
	avl_addr_t avl_address;
	avl_data_t avl_writedata;
	avl_data_t avl_readdata;
	logic      avl_waitrequest;
	logic      afi_cal_success;
	logic      afi_cal_fail;
	wlat_t     afi_wlat;
	rlat_t     afi_rlat;
	mem_cmd_t  afi_cmd;
	logic      afi_mem_clk_disable;
	mem_cmd_t  mem_cmd;
	logic      mem_ck_en;
	logic      afi_wdata_valid;
	dq_t       afi_wdata;
	dm_t       afi_dm;
	logic      afi_rdata_en;
	dq_t       afi_rdata;
	logic      afi_rdata_valid;
	dq_t       mem_dq_out;
	logic      mem_dq_oe;
	dm_t       mem_dm;
	dq_t       mem_dq_in;

	int          errors;
	int          checks;
	logic [31:0] lfsr_state;

	phy_top u_dut (.*);

	initial begin
		pll_afi_clk = 1'b0;
		forever #(CLK_PERIOD / 2) pll_afi_clk = ~pll_afi_clk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic mem_cmd_t idle_cmd();
		mem_cmd_t c;
		c       = '0;
		c.cs_n  = 1'b1;
		c.ras_n = 1'b1;
		c.cas_n = 1'b1;
		c.we_n  = 1'b1;
		return c;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at time %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("timeout at time %0t while waiting for %s", $time, what);
	endtask

	// Counts rising edges until afi_reset_n is seen high
	task automatic wait_reset_release(output int edges);
		edges = 0;
		@(negedge pll_afi_clk);
		while (!afi_reset_n && edges < WAIT_LIMIT) begin
			@(posedge pll_afi_clk);
			edges++;
			@(negedge pll_afi_clk);
		end
		if (!afi_reset_n) begin
			report_timeout("afi_reset_n to rise");
		end
	endtask

	task automatic write_csr(input avl_addr_t addr, input avl_data_t data);
		@(posedge pll_afi_clk);
		avl_write     <= 1'b1;
		avl_address   <= addr;
		avl_writedata <= data;
		@(negedge pll_afi_clk);
		check_val("avl_waitrequest on write", avl_waitrequest, 1'b0);
		@(posedge pll_afi_clk);
		avl_write <= 1'b0;
	endtask

	// Master holds the read until waitrequest drops
	task automatic read_csr(input avl_addr_t addr, output avl_data_t data);
		int waits;
		waits = 0;
		@(posedge pll_afi_clk);
		avl_read    <= 1'b1;
		avl_address <= addr;
		@(negedge pll_afi_clk);
		while (avl_waitrequest && waits < WAIT_LIMIT) begin
			waits++;
			@(negedge pll_afi_clk);
		end
		if (avl_waitrequest) begin
			report_timeout("avl_waitrequest to fall");
		end
		data = avl_readdata;
		check_val("avl_waitrequest cycles", waits, 1);
		@(posedge pll_afi_clk);
		avl_read <= 1'b0;
	endtask

	task automatic check_reset_values();
		avl_data_t rd;
		check_val("mem_cmd.cs_n", mem_cmd.cs_n, 1'b1);
		check_val("mem_cmd.cke", mem_cmd.cke, 1'b0);
		check_val("mem_cmd.rst_n", mem_cmd.rst_n, 1'b0);
		check_val("mem_ck_en", mem_ck_en, 1'b0);
		check_val("mem_dq_oe", mem_dq_oe, 1'b0);
		check_val("afi_rdata_valid", afi_rdata_valid, 1'b0);
		check_val("afi_cal_success", afi_cal_success, 1'b0);
		check_val("afi_cal_fail", afi_cal_fail, 1'b0);
		check_val("afi_wlat", afi_wlat, WLAT_DEFAULT);
		check_val("afi_rlat", afi_rlat, RLAT_DEFAULT);
		read_csr(REG_CALIB, rd);
		check_val("REG_CALIB after reset", rd, CALIB_INIT);
	endtask

	task automatic pulse_reset_source(input bit use_pll, input string name);
		int edges;
		@(posedge pll_afi_clk);
		if (use_pll) pll_locked <= 1'b0;
		else soft_reset_n <= 1'b0;
		@(negedge pll_afi_clk);
		check_val({name, " low, afi_reset_n"}, afi_reset_n, 1'b0);
		repeat (3) @(posedge pll_afi_clk);
		if (use_pll) pll_locked <= 1'b1;
		else soft_reset_n <= 1'b1;
		wait_reset_release(edges);
		check_val({name, " release edges"}, edges, RESET_SYNC_STAGES);
	endtask

	task automatic write_status(input avl_data_t bits, input logic succ, input logic fail);
		avl_data_t rd;
		write_csr(REG_STATUS, bits);
		@(negedge pll_afi_clk);
		check_val("afi_cal_success", afi_cal_success, succ);
		check_val("afi_cal_fail", afi_cal_fail, fail);
		read_csr(REG_STATUS, rd);
		check_val("REG_STATUS", rd, {30'd0, fail, succ});
	endtask

	task automatic access_registers();
		avl_data_t   rd;
		logic [31:0] r;
		write_csr(REG_WLAT, 32'd5);
		read_csr(REG_WLAT, rd);
		check_val("REG_WLAT", rd, 32'd5);
		write_csr(REG_RLAT, 32'd9);
		read_csr(REG_RLAT, rd);
		check_val("REG_RLAT", rd, 32'd9);
		r = rand_bits(8);
		write_csr(REG_CALIB, r);
		read_csr(REG_CALIB, rd);
		check_val("REG_CALIB", rd, r);
		write_status(32'd1, 1'b1, 1'b0);
		write_status(32'd2, 1'b0, 1'b1);
		write_status(32'd3, 1'b0, 1'b1);
		write_csr(avl_addr_t'(12), 32'hffff_ffff);
		read_csr(avl_addr_t'(12), rd);
		check_val("unused register", rd, 32'd0);
	endtask

	task automatic stream_commands();
		mem_cmd_t    prev_cmd;
		mem_cmd_t    cur_cmd;
		logic        prev_dis;
		logic [31:0] r;
		prev_cmd = idle_cmd();
		prev_dis = 1'b1;
		for (int c = 0; c <= 20; c++) begin
			@(posedge pll_afi_clk);
			r       = rand_bits(25);
			cur_cmd = r[24:0];
			if (c < 20) begin
				afi_cmd             <= cur_cmd;
				afi_mem_clk_disable <= c[0];
			end
			@(negedge pll_afi_clk);
			if (c > 0) begin
				check_val("mem_cmd", mem_cmd, prev_cmd);
				check_val("mem_ck_en", mem_ck_en, !prev_dis);
			end
			prev_cmd = cur_cmd;
			prev_dis = c[0];
		end
	endtask

	// Sampled one edge after the drive, then WR_TEST_LAT edges to the pins
	task automatic stream_write_beats();
		logic        exp_v [64];
		dq_t         exp_d [64];
		dm_t         exp_m [64];
		logic [31:0] r;
		logic        v;
		for (int i = 0; i < 64; i++) begin
			exp_v[i] = 1'b0;
		end
		write_csr(REG_WLAT, WR_TEST_LAT);
		for (int c = 0; c < BEATS + WR_TEST_LAT + 2; c++) begin
			@(posedge pll_afi_clk);
			if (c < BEATS) begin
				r = rand_bits(1);
				v = (c < 5) | r[0];
				r = rand_bits(18);
				afi_wdata_valid <= v;
				afi_wdata       <= r[15:0];
				afi_dm          <= r[17:16];
				exp_v[c + WR_TEST_LAT + 1] = v;
				exp_d[c + WR_TEST_LAT + 1] = r[15:0];
				exp_m[c + WR_TEST_LAT + 1] = r[17:16];
			end else begin
				afi_wdata_valid <= 1'b0;
			end
			@(negedge pll_afi_clk);
			check_val("mem_dq_oe", mem_dq_oe, exp_v[c]);
			if (exp_v[c]) begin
				check_val("mem_dq_out", mem_dq_out, exp_d[c]);
				check_val("mem_dm", mem_dm, exp_m[c]);
			end
		end
	endtask

	task automatic stream_read_enables();
		logic        exp_v [64];
		int          src   [64];
		dq_t         drv   [64];
		logic [31:0] r;
		logic        en;
		for (int i = 0; i < 64; i++) begin
			exp_v[i] = 1'b0;
		end
		write_csr(REG_RLAT, RD_TEST_LAT);
		for (int c = 0; c < BEATS + RD_TEST_LAT + 2; c++) begin
			@(posedge pll_afi_clk);
			r      = rand_bits(16);
			drv[c] = r[15:0];
			mem_dq_in <= r[15:0];
			en = 1'b0;
			if (c < BEATS) begin
				r  = rand_bits(1);
				en = (c < 3) | r[0];
			end
			afi_rdata_en <= en;
			if (en) begin
				exp_v[c + RD_TEST_LAT + 1] = 1'b1;
				src[c + RD_TEST_LAT + 1]   = c + RD_TEST_LAT - 1;
			end
			@(negedge pll_afi_clk);
			check_val("afi_rdata_valid", afi_rdata_valid, exp_v[c]);
			if (exp_v[c]) begin
				check_val("afi_rdata", afi_rdata, drv[src[c]]);
			end
		end
	endtask

	initial begin
		int edges;
		errors              = 0;
		checks              = 0;
		lfsr_state          = LFSR_SEED;
		rst_n               = 1'b0;
		soft_reset_n        = 1'b1;
		pll_locked          = 1'b1;
		avl_read            = 1'b0;
		avl_write           = 1'b0;
		avl_address         = '0;
		avl_writedata       = '0;
		afi_cmd             = idle_cmd();
		afi_mem_clk_disable = 1'b1;
		afi_wdata_valid     = 1'b0;
		afi_wdata           = '0;
		afi_dm              = '0;
		afi_rdata_en        = 1'b0;
		mem_dq_in           = '0;
		repeat (10) @(posedge pll_afi_clk);
		rst_n <= 1'b1;
		wait_reset_release(edges);
		check_val("rst_n release edges", edges, RESET_SYNC_STAGES);
		check_reset_values();
		pulse_reset_source(1'b1, "pll_locked");
		pulse_reset_source(1'b0, "soft_reset_n");
		access_registers();
		stream_commands();
		stream_write_beats();
		stream_read_enables();
		repeat (2) @(posedge pll_afi_clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// Overall limit on run time
	initial begin
		#100000;
		$display("simulation ran past its time limit");
		$display("Checks: %0d, errors: %0d", checks, errors + 1);
		$display("Finished with errors");
		$finish;
	end

endmodule
